// ==== tb.f ====
hdl/periph_pkg.sv
hdl/apb_interconnect.sv
hdl/gpio_regs.sv
hdl/scratch_ram.sv
hdl/periph_top.sv
dv/periph_properties.sv
dv/periph_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line in the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
    --top-module periph_tb -f tb.f
./obj_dir/Vperiph_tb +verilator+error+limit+100 | tee sim.log

if grep -qx "Test passed" sim.log; then
    echo "simulation result: pass"
else
    echo "simulation result: fail"
    exit 1
fi

// ==== dv/periph_tb.sv ====
/* Drives the master port of periph_top with the package's default address map.
   Read data is checked against byte-strobe models of the GPIO and RAM words. */

`timescale 1ns/100ps

module periph_tb;

    localparam int  AW        = periph_pkg::ADDRW;
    localparam int  DW        = periph_pkg::XLEN;
    localparam int  SW        = periph_pkg::STRBW;
    localparam int  RAM_WORDS = periph_pkg::RAM_SIZE / 4;
    localparam int  N_GPIO    = 8;
    localparam time PERIOD    = 40;
    localparam time DRV_DLY   = 2;
    localparam logic [AW-1:0] GPIO_OUT_A = AW'(periph_pkg::GPIO_BASE);
    localparam logic [AW-1:0] GPIO_IN_A  = AW'(periph_pkg::GPIO_BASE + 4);
    // Every access of every test at the RAM latency plus the idle gap
    localparam int  ACCESSES  = 2 * N_GPIO + 9 + 5 * RAM_WORDS + 8;
    localparam time WATCHDOG  = 2 * (ACCESSES * (periph_pkg::RAM_WAIT + 4) + 40) * PERIOD;

    logic          aclk;
    logic          aresetn;
    logic          srst;
    logic          slv_en;
    logic          slv_wr;
    logic [AW-1:0] slv_addr;
    logic [DW-1:0] slv_wdata;
    logic [SW-1:0] slv_strb;
    logic [DW-1:0] slv_rdata;
    logic          slv_ready;
    logic [DW-1:0] gpio_in;
    logic [DW-1:0] gpio_out;

    logic [31:0]   rng = 32'd40;
    logic [DW-1:0] rd_data;
    logic [DW-1:0] gpio_model;
    logic [DW-1:0] ram_model [RAM_WORDS];
    int            test_errors;
    int            errors;
    int            tests_run;
    int            tests_failed;

    periph_top DUT (.*);

    always #(PERIOD / 2) aclk = ~aclk;

    function automatic logic [31:0] draw_random();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic logic [DW-1:0] merge_bytes(input logic [DW-1:0] old,
                                                  input logic [DW-1:0] data,
                                                  input logic [SW-1:0] strb);
        logic [DW-1:0] m;
        m = old;
        for (int i = 0; i < SW; i++) begin
            if (strb[i]) begin
                m[8*i +: 8] = data[8*i +: 8];
            end
        end
        return m;
    endfunction

    function automatic logic [AW-1:0] ram_addr(input int w);
        return AW'(periph_pkg::RAM_BASE + 4 * w);
    endfunction

    // One access with en held until ready
    task automatic bus_access(input logic wr, input logic [AW-1:0] addr,
                              input logic [DW-1:0] wdata, input logic [SW-1:0] strb);
        @(posedge aclk);
        #(DRV_DLY);
        slv_en    = 1'b1;
        slv_wr    = wr;
        slv_addr  = addr;
        slv_wdata = wdata;
        slv_strb  = strb;
        do begin
            @(posedge aclk);
            #(DRV_DLY);
        end while (!slv_ready);
        rd_data = slv_rdata;
        slv_en  = 1'b0;
    endtask

    task automatic check_equal(input string name, input logic [DW-1:0] exp,
                               input logic [DW-1:0] got);
        assert (got === exp)
        else begin
            $display("ERR %s expected %08h got %08h", name, exp, got);
            test_errors++;
        end
    endtask

    task automatic check_read(input logic [AW-1:0] addr, input logic [DW-1:0] exp);
        bus_access(1'b0, addr, '0, '0);
        check_equal("slv_rdata", exp, rd_data);
    endtask

    task automatic check_unmapped(input logic [AW-1:0] addr);
        bus_access(1'b1, addr, draw_random(), '1);
        check_read(addr, '0);
    endtask

    task automatic end_test(input string name);
        $display("%-12s %0d errors", name, test_errors);
        tests_run++;
        errors += test_errors;
        if (test_errors != 0) begin
            tests_failed++;
        end
        test_errors = 0;
    endtask

    initial begin
        logic [DW-1:0] data;
        logic [SW-1:0] strb;
        int            assert_fails;

        aclk         = 1'b0;
        aresetn      = 1'b0;
        srst         = 1'b0;
        slv_en       = 1'b0;
        slv_wr       = 1'b0;
        slv_addr     = '0;
        slv_wdata    = '0;
        slv_strb     = '0;
        gpio_in      = '0;
        gpio_model   = '0;
        test_errors  = 0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        repeat (4) @(posedge aclk);
        #(DRV_DLY);
        aresetn = 1'b1;

        for (int n = 0; n < N_GPIO; n++) begin
            data = draw_random();
            strb = SW'(draw_random());
            bus_access(1'b1, GPIO_OUT_A, data, strb);
            gpio_model = merge_bytes(gpio_model, data, strb);
            check_equal("gpio_out", gpio_model, gpio_out);
            check_read(GPIO_OUT_A, gpio_model);
        end
        end_test("gpio_out");

        // Input word is read only
        for (int n = 0; n < 3; n++) begin
            gpio_in = draw_random();
            repeat (4) @(posedge aclk);
            check_read(GPIO_IN_A, gpio_in);
            bus_access(1'b1, GPIO_IN_A, draw_random(), '1);
            check_read(GPIO_IN_A, gpio_in);
            check_equal("gpio_out", gpio_model, gpio_out);
        end
        end_test("gpio_in");

        for (int w = 0; w < RAM_WORDS; w++) begin
            ram_model[w] = draw_random();
            bus_access(1'b1, ram_addr(w), ram_model[w], '1);
        end
        for (int n = 0; n < 2 * RAM_WORDS; n++) begin
            data = draw_random();
            strb = SW'(draw_random());
            bus_access(1'b1, ram_addr(n % RAM_WORDS), data, strb);
            ram_model[n % RAM_WORDS] = merge_bytes(ram_model[n % RAM_WORDS], data, strb);
        end
        for (int w = 0; w < RAM_WORDS; w++) begin
            check_read(ram_addr(w), ram_model[w]);
        end
        end_test("ram");

        // Gap between windows, past the RAM, top of the address space
        check_unmapped(AW'(periph_pkg::GPIO_BASE + periph_pkg::GPIO_SIZE));
        check_unmapped(AW'(periph_pkg::RAM_BASE + periph_pkg::RAM_SIZE));
        check_unmapped(~AW'(3));
        end_test("unmapped");

        gpio_model = draw_random() | 32'h1;
        bus_access(1'b1, GPIO_OUT_A, gpio_model, '1);
        @(posedge aclk);
        #(DRV_DLY);
        srst = 1'b1;
        @(posedge aclk);
        #(DRV_DLY);
        srst       = 1'b0;
        gpio_model = '0;
        check_equal("gpio_out", gpio_model, gpio_out);
        check_read(GPIO_OUT_A, gpio_model);
        for (int w = 0; w < RAM_WORDS; w++) begin
            check_read(ram_addr(w), ram_model[w]);
        end
        end_test("soft_reset");

        assert_fails = DUT.u_props.fail_count;
        $display("%0d tests, %0d with errors, %0d check errors, %0d assertion failures",
                 tests_run, tests_failed, errors, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG);
        $display("Timeout: accesses did not complete within %0t", WATCHDOG);
        $display("Test failed");
        $finish;
    end

endmodule

// ==== dv/periph_properties.sv ====
/* Bus protocol checks, bound into periph_top. The unmapped check follows the
   default address map of the package. */

`timescale 1ns/100ps

module periph_properties #(
    parameter int MAX_WAIT = 16
)(
    input logic                          aclk,
    input logic                          aresetn,
    input logic                          srst,
    input logic                          slv_en,
    input logic [periph_pkg::ADDRW -1:0] slv_addr,
    input logic                          slv_ready,
    input logic                          mst0_en,
    input logic                          mst1_en,
    input logic [periph_pkg::XLEN  -1:0] gpio_out
);

    int          fail_count = 0;
    int unsigned addr_ext;
    int unsigned wait_cnt;
    logic        gpio_hit;
    logic        ram_hit;

    assign addr_ext = 32'(slv_addr);
    assign gpio_hit = addr_ext >= periph_pkg::GPIO_BASE &&
                      addr_ext < periph_pkg::GPIO_BASE + periph_pkg::GPIO_SIZE;
    assign ram_hit  = addr_ext >= periph_pkg::RAM_BASE &&
                      addr_ext < periph_pkg::RAM_BASE + periph_pkg::RAM_SIZE;

    // Cycles an open access has waited for ready
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            wait_cnt <= 0;
        end else if (slv_en && !slv_ready) begin
            wait_cnt <= wait_cnt + 1;
        end else begin
            wait_cnt <= 0;
        end
    end

    ready_single: assert property (@(posedge aclk) disable iff (!aresetn)
        slv_ready |=> !slv_ready)
        else begin
            $error("slv_ready high on two consecutive cycles");
            fail_count++;
        end

    one_slave: assert property (@(posedge aclk) disable iff (!aresetn)
        !(mst0_en && mst1_en))
        else begin
            $error("both slave enables high at once");
            fail_count++;
        end

    unmapped_quiet: assert property (@(posedge aclk) disable iff (!aresetn)
        (slv_en && !gpio_hit && !ram_hit) |-> (!mst0_en && !mst1_en))
        else begin
            $error("slave enable raised for an unmapped address");
            fail_count++;
        end

    ready_bound: assert property (@(posedge aclk) disable iff (!aresetn)
        wait_cnt < MAX_WAIT)
        else begin
            $error("access got no ready within the wait limit");
            fail_count++;
        end

    srst_idle: assert property (@(posedge aclk) disable iff (!aresetn)
        srst |=> (!mst0_en && !mst1_en && !slv_ready && gpio_out == '0))
        else begin
            $error("bus state or gpio_out not cleared by soft reset");
            fail_count++;
        end

endmodule

bind periph_top periph_properties u_props (.*);

// ==== hdl/periph_top.sv ====
/* GPIO at slave 0, scratch RAM at slave 1. SLV1_SIZE must be a power-of-two number of
   words, at least two. */

`timescale 1ns/100ps

module periph_top

    #(
        parameter int unsigned SLV0_ADDR = periph_pkg::GPIO_BASE,
        parameter int unsigned SLV0_SIZE = periph_pkg::GPIO_SIZE,
        parameter int unsigned SLV1_ADDR = periph_pkg::RAM_BASE,
        parameter int unsigned SLV1_SIZE = periph_pkg::RAM_SIZE,
        parameter int          GPIO_W    = periph_pkg::XLEN,
        parameter int          RAM_WAIT  = periph_pkg::RAM_WAIT
    )(
        input  logic                            aclk,
        input  logic                            aresetn,
        input  logic                            srst,
        input  logic                            slv_en,
        input  logic                            slv_wr,
        input  logic [periph_pkg::ADDRW   -1:0] slv_addr,
        input  logic [periph_pkg::XLEN    -1:0] slv_wdata,
        input  logic [periph_pkg::STRBW   -1:0] slv_strb,
        output logic [periph_pkg::XLEN    -1:0] slv_rdata,
        output logic                            slv_ready,
        input  logic [GPIO_W              -1:0] gpio_in,
        output logic [GPIO_W              -1:0] gpio_out
    );

    logic                          mst0_en;
    logic                          mst0_wr;
    logic [periph_pkg::ADDRW-1:0]  mst0_addr;
    logic [periph_pkg::XLEN-1:0]   mst0_wdata;
    logic [periph_pkg::STRBW-1:0]  mst0_strb;
    logic [periph_pkg::XLEN-1:0]   mst0_rdata;
    logic                          mst0_ready;

    logic                          mst1_en;
    logic                          mst1_wr;
    logic [periph_pkg::ADDRW-1:0]  mst1_addr;
    logic [periph_pkg::XLEN-1:0]   mst1_wdata;
    logic [periph_pkg::STRBW-1:0]  mst1_strb;
    logic [periph_pkg::XLEN-1:0]   mst1_rdata;
    logic                          mst1_ready;

    apb_interconnect #(
        .SLV0_ADDR (SLV0_ADDR),
        .SLV0_SIZE (SLV0_SIZE),
        .SLV1_ADDR (SLV1_ADDR),
        .SLV1_SIZE (SLV1_SIZE)
    ) u_icn (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .srst       (srst),
        .slv_en     (slv_en),
        .slv_wr     (slv_wr),
        .slv_addr   (slv_addr),
        .slv_wdata  (slv_wdata),
        .slv_strb   (slv_strb),
        .slv_rdata  (slv_rdata),
        .slv_ready  (slv_ready),
        .mst0_en    (mst0_en),
        .mst0_wr    (mst0_wr),
        .mst0_addr  (mst0_addr),
        .mst0_wdata (mst0_wdata),
        .mst0_strb  (mst0_strb),
        .mst0_rdata (mst0_rdata),
        .mst0_ready (mst0_ready),
        .mst1_en    (mst1_en),
        .mst1_wr    (mst1_wr),
        .mst1_addr  (mst1_addr),
        .mst1_wdata (mst1_wdata),
        .mst1_strb  (mst1_strb),
        .mst1_rdata (mst1_rdata),
        .mst1_ready (mst1_ready)
    );

    gpio_regs #(
        .GPIO_W (GPIO_W)
    ) u_gpio (
        .aclk     (aclk),
        .aresetn  (aresetn),
        .srst     (srst),
        .en       (mst0_en),
        .wr       (mst0_wr),
        .addr     (mst0_addr),
        .wdata    (mst0_wdata),
        .strb     (mst0_strb),
        .rdata    (mst0_rdata),
        .ready    (mst0_ready),
        .gpio_in  (gpio_in),
        .gpio_out (gpio_out)
    );

    // Depth in words from the window size in bytes
    scratch_ram #(
        .DEPTH (SLV1_SIZE / 4),
        .WAIT  (RAM_WAIT)
    ) u_ram (
        .aclk    (aclk),
        .aresetn (aresetn),
        .srst    (srst),
        .en      (mst1_en),
        .wr      (mst1_wr),
        .addr    (mst1_addr),
        .wdata   (mst1_wdata),
        .strb    (mst1_strb),
        .rdata   (mst1_rdata),
        .ready   (mst1_ready)
    );

endmodule

// ==== hdl/scratch_ram.sv ====
/* Word array with byte strobes; addresses beyond DEPTH words alias. DEPTH must be a power
   of two, at least 2. Contents survive srst and power up undefined. */

`timescale 1ns/100ps

module scratch_ram

    #(
        parameter int DEPTH = 4,
        parameter int WAIT  = 2
    )(
        input  logic                            aclk,
        input  logic                            aresetn,
        input  logic                            srst,
        input  logic                            en,
        input  logic                            wr,
        input  logic [periph_pkg::ADDRW   -1:0] addr,
        input  logic [periph_pkg::XLEN    -1:0] wdata,
        input  logic [periph_pkg::STRBW   -1:0] strb,
        output logic [periph_pkg::XLEN    -1:0] rdata,
        output logic                            ready
    );

    localparam int IDXW  = $clog2(DEPTH);
    localparam int CNTW  = (WAIT > 1) ? $clog2(WAIT) : 1;
    localparam int LOADV = (WAIT > 0) ? WAIT - 1 : 0;
    localparam logic [CNTW-1:0] LOAD = LOADV[CNTW-1:0];

    logic [periph_pkg::XLEN-1:0] mem [DEPTH];
    logic [IDXW-1:0]             idx;
    logic [CNTW-1:0]             cnt;
    logic                        busy;
    logic                        done;
    logic                        fire;

    assign idx = addr[IDXW+1:2];

    // Cycle where the access takes effect
    assign fire = !srst && !done &&
                  ((busy && cnt == 0) || (en && !busy && WAIT == 0));

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            ready <= 1'b0;
            busy  <= 1'b0;
            done  <= 1'b0;
            cnt   <= '0;
        end else if (srst) begin
            ready <= 1'b0;
            busy  <= 1'b0;
            done  <= 1'b0;
            cnt   <= '0;
        end else begin
            ready <= fire;
            if (fire) begin
                busy <= 1'b0;
                done <= 1'b1;
            end else if (done) begin
                done <= en;
            end else if (busy) begin
                cnt <= cnt - 1'b1;
            end else if (en) begin
                busy <= 1'b1;
                cnt  <= LOAD;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (fire) begin
            rdata <= mem[idx];
            if (wr) begin
                for (int i = 0; i < periph_pkg::STRBW; i++) begin
                    if (strb[i]) begin
                        mem[idx][8*i +: 8] <= wdata[8*i +: 8];
                    end
                end
            end
        end
    end

endmodule

// ==== hdl/gpio_regs.sv ====
/* Word 0 is the output register, word 1 the synchronised inputs (read only).
   GPIO_W must not exceed the bus width; output bits above GPIO_W read back but drive no pin. */

`timescale 1ns/100ps

module gpio_regs

    #(
        parameter int GPIO_W = 32
    )(
        input  logic                            aclk,
        input  logic                            aresetn,
        input  logic                            srst,
        input  logic                            en,
        input  logic                            wr,
        input  logic [periph_pkg::ADDRW   -1:0] addr,
        input  logic [periph_pkg::XLEN    -1:0] wdata,
        input  logic [periph_pkg::STRBW   -1:0] strb,
        output logic [periph_pkg::XLEN    -1:0] rdata,
        output logic                            ready,
        input  logic [GPIO_W              -1:0] gpio_in,
        output logic [GPIO_W              -1:0] gpio_out
    );

    logic [periph_pkg::XLEN-1:0] out_reg;
    logic [periph_pkg::XLEN-1:0] in_word;
    logic [GPIO_W-1:0]           in_meta;
    logic [GPIO_W-1:0]           in_sync;
    logic                        done;
    logic                        accept;
    logic                        sel_out;
    logic                        sel_in;

    assign accept  = en && !done;
    assign sel_out = addr[periph_pkg::ADDRW-1:2] == 0;
    assign sel_in  = addr[periph_pkg::ADDRW-1:2] == 1;

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            ready   <= 1'b0;
            done    <= 1'b0;
            out_reg <= '0;
        end else if (srst) begin
            ready   <= 1'b0;
            done    <= 1'b0;
            out_reg <= '0;
        end else begin
            ready <= 1'b0;
            if (accept) begin
                ready <= 1'b1;
                done  <= 1'b1;
                if (wr && sel_out) begin
                    for (int i = 0; i < periph_pkg::STRBW; i++) begin
                        if (strb[i]) begin
                            out_reg[8*i +: 8] <= wdata[8*i +: 8];
                        end
                    end
                end
            end else if (!en) begin
                // Requester has released the bus
                done <= 1'b0;
            end
        end
    end

    // Two-flop synchroniser on the pins
    always_ff @(posedge aclk) begin
        in_meta <= gpio_in;
        in_sync <= in_meta;
    end

    always_comb begin
        in_word             = '0;
        in_word[GPIO_W-1:0] = in_sync;
    end

    always_ff @(posedge aclk) begin
        if (accept) begin
            rdata <= sel_out ? out_reg : (sel_in ? in_word : '0);
        end
    end

    assign gpio_out = out_reg[GPIO_W-1:0];

endmodule

// ==== hdl/apb_interconnect.sv ====
/* One master, two slaves, one access in flight. Window sizes must fit in ADDRW bits;
   slave 0 wins if the windows overlap. Unmapped accesses complete with zero data. */

`timescale 1ns/100ps

module apb_interconnect

    #(
        parameter int unsigned SLV0_ADDR = 0,
        parameter int unsigned SLV0_SIZE = 8,
        parameter int unsigned SLV1_ADDR = 16,
        parameter int unsigned SLV1_SIZE = 16
    )(
        input  logic                            aclk,
        input  logic                            aresetn,
        input  logic                            srst,
        // Master side
        input  logic                            slv_en,
        input  logic                            slv_wr,
        input  logic [periph_pkg::ADDRW   -1:0] slv_addr,
        input  logic [periph_pkg::XLEN    -1:0] slv_wdata,
        input  logic [periph_pkg::STRBW   -1:0] slv_strb,
        output logic [periph_pkg::XLEN    -1:0] slv_rdata,
        output logic                            slv_ready,
        // Slave 0
        output logic                            mst0_en,
        output logic                            mst0_wr,
        output logic [periph_pkg::ADDRW   -1:0] mst0_addr,
        output logic [periph_pkg::XLEN    -1:0] mst0_wdata,
        output logic [periph_pkg::STRBW   -1:0] mst0_strb,
        input  logic [periph_pkg::XLEN    -1:0] mst0_rdata,
        input  logic                            mst0_ready,
        // Slave 1
        output logic                            mst1_en,
        output logic                            mst1_wr,
        output logic [periph_pkg::ADDRW   -1:0] mst1_addr,
        output logic [periph_pkg::XLEN    -1:0] mst1_wdata,
        output logic [periph_pkg::STRBW   -1:0] mst1_strb,
        input  logic [periph_pkg::XLEN    -1:0] mst1_rdata,
        input  logic                            mst1_ready
    );

    localparam logic [periph_pkg::ADDRW-1:0] S0_BASE = SLV0_ADDR[periph_pkg::ADDRW-1:0];
    localparam logic [periph_pkg::ADDRW-1:0] S0_SIZE = SLV0_SIZE[periph_pkg::ADDRW-1:0];
    localparam logic [periph_pkg::ADDRW-1:0] S1_BASE = SLV1_ADDR[periph_pkg::ADDRW-1:0];
    localparam logic [periph_pkg::ADDRW-1:0] S1_SIZE = SLV1_SIZE[periph_pkg::ADDRW-1:0];

    logic [periph_pkg::ADDRW-1:0] slv0_off;
    logic [periph_pkg::ADDRW-1:0] slv1_off;
    logic                         slv0_hit;
    logic                         slv1_hit;
    logic                         req;

    // Offset wraps high below the base, so one compare covers both bounds
    assign slv0_off = slv_addr - S0_BASE;
    assign slv1_off = slv_addr - S1_BASE;
    assign slv0_hit = slv0_off < S0_SIZE;
    assign slv1_hit = !slv0_hit && (slv1_off < S1_SIZE);

    // Access open and not yet acknowledged
    assign req = slv_en && !slv_ready;

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            mst0_en   <= 1'b0;
            mst1_en   <= 1'b0;
            slv_ready <= 1'b0;
            slv_rdata <= '0;
        end else if (srst) begin
            mst0_en   <= 1'b0;
            mst1_en   <= 1'b0;
            slv_ready <= 1'b0;
            slv_rdata <= '0;
        end else if (req) begin
            if (slv0_hit) begin
                mst0_en   <= !mst0_ready;
                mst1_en   <= 1'b0;
                slv_ready <= mst0_ready;
                slv_rdata <= mst0_ready ? mst0_rdata : '0;
            end else if (slv1_hit) begin
                mst0_en   <= 1'b0;
                mst1_en   <= !mst1_ready;
                slv_ready <= mst1_ready;
                slv_rdata <= mst1_ready ? mst1_rdata : '0;
            end else begin
                // Nothing mapped here
                mst0_en   <= 1'b0;
                mst1_en   <= 1'b0;
                slv_ready <= 1'b1;
                slv_rdata <= '0;
            end
        end else begin
            mst0_en   <= 1'b0;
            mst1_en   <= 1'b0;
            slv_ready <= 1'b0;
            slv_rdata <= '0;
        end
    end

    // Request fields follow the master while the window matches
    always_ff @(posedge aclk) begin
        if (req && slv0_hit) begin
            mst0_wr    <= slv_wr;
            mst0_addr  <= slv0_off;
            mst0_wdata <= slv_wdata;
            mst0_strb  <= slv_strb;
        end else begin
            mst0_wr    <= 1'b0;
            mst0_addr  <= '0;
            mst0_wdata <= '0;
            mst0_strb  <= '0;
        end

        if (req && slv1_hit) begin
            mst1_wr    <= slv_wr;
            mst1_addr  <= slv1_off;
            mst1_wdata <= slv_wdata;
            mst1_strb  <= slv_strb;
        end else begin
            mst1_wr    <= 1'b0;
            mst1_addr  <= '0;
            mst1_wdata <= '0;
            mst1_strb  <= '0;
        end
    end

endmodule

// ==== hdl/periph_pkg.sv ====
/* Bus widths and the default address map of the peripheral subsystem.
   Windows are byte addressed, word aligned, and must not overlap. */

package periph_pkg;

    // Register bus widths
    localparam int ADDRW = 16;
    localparam int XLEN  = 32;
    localparam int STRBW = XLEN / 8;

    // GPIO window of two words
    localparam int unsigned GPIO_BASE = 0;
    localparam int unsigned GPIO_SIZE = 8;

    // Scratch RAM window of four words
    localparam int unsigned RAM_BASE = 16;
    localparam int unsigned RAM_SIZE = 16;

    // Extra wait cycles of the RAM
    localparam int unsigned RAM_WAIT = 2;

endpackage
